// File: source/axil_pkg.sv
package axil_pkg;

    // Bus widths
    parameter int addr_w = 32;
    parameter int data_w = 32;
    parameter int strb_w = data_w / 8;   // One strobe bit per byte lane

    // Host command opcode
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } axil_op_e;

    // AXI response codes, only the two the bank can return
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

    // Command from the host, 69 bits
    typedef struct packed {
        axil_op_e            op;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;   // Ignored on reads
        logic [strb_w-1:0]   wstrb;   // Ignored on reads
    } axil_cmd_t;

    // Result back to the host, 35 bits
    typedef struct packed {
        axil_op_e            op;      // Echo of the command opcode
        axil_resp_e          resp;
        logic [data_w-1:0]   rdata;   // Zero for writes
    } axil_rsp_t;

    // Contents of the AW and W channels
    // Both channels are raised together by the master, so they share one bundle
    typedef struct packed {
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
        logic [strb_w-1:0]   wstrb;
    } axil_aw_t;

endpackage

// File: source/axil_cmd_fifo.sv
`timescale 1ns/10ps

module axil_cmd_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_cmd_t cmd,
    input  logic                cmd_req,
    output logic                cmd_ack,
    output axil_pkg::axil_cmd_t fifo_cmd,
    output logic                fifo_valid,
    input  logic                fifo_pop
);
    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);

    axil_pkg::axil_cmd_t mem [fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             full;
    logic             push;

    assign full = (count == cnt_w'(fifo_depth));

    // New request, not yet acked, and room for it
    assign push = cmd_req && !cmd_ack && !full;

    assign fifo_valid = (count != '0);
    assign fifo_cmd   = mem[rd_ptr];

    // Four-phase acknowledge toward the host
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_ack <= 1'b0;
        end else if (push) begin
            cmd_ack <= 1'b1;
        end else if (!cmd_req) begin
            cmd_ack <= 1'b0;   // Host dropped req, release ack
        end
    end

    // Storage, written in the same edge that raises cmd_ack
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd;
        end
    end

    // Pointers wrap at fifo_depth
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // The master must only take an entry that is there
    assert property (@(posedge clk) disable iff (rst) fifo_pop |-> count != '0)
        else $error("Pop from empty command FIFO");

endmodule

// File: source/axil_master.sv
`timescale 1ns/10ps

module axil_master (
    input  logic                              clk,
    input  logic                              rst,
    input  axil_pkg::axil_cmd_t               fifo_cmd,
    input  logic                              fifo_valid,
    output logic                              fifo_pop,
    output axil_pkg::axil_aw_t                aw,
    output logic                              awvalid,
    output logic                              wvalid,
    input  logic                              awready,
    input  logic                              wready,
    input  axil_pkg::axil_resp_e              bresp,
    input  logic                              bvalid,
    output logic                              bready,
    output logic [axil_pkg::addr_w-1:0]       araddr,
    output logic                              arvalid,
    input  logic                              arready,
    input  logic [axil_pkg::data_w-1:0]       rdata,
    input  axil_pkg::axil_resp_e              rresp,
    input  logic                              rvalid,
    output logic                              rready,
    output axil_pkg::axil_rsp_t               rsp,
    output logic                              rsp_req,
    input  logic                              rsp_ack
);
    typedef enum logic [2:0] {
        IDLE,
        WR_ADDR,
        WR_RESP,
        RD_ADDR,
        RD_DATA,
        RSP_HOLD,
        RSP_WAIT
    } state_e;

    state_e              state;
    axil_pkg::axil_cmd_t cmd_q;    // Command currently on the bus
    logic                aw_done;  // AW accepted, W may still be pending
    logic                w_done;
    logic                aw_xfer;
    logic                w_xfer;
    logic                wr_addr_done;

    // Take the head entry only when nothing is in flight
    assign fifo_pop = (state == IDLE) && fifo_valid;

    assign awvalid = (state == WR_ADDR) && !aw_done;
    assign wvalid  = (state == WR_ADDR) && !w_done;
    assign bready  = (state == WR_RESP);
    assign arvalid = (state == RD_ADDR);
    assign rready  = (state == RD_DATA);
    assign rsp_req = (state == RSP_HOLD);

    assign aw_xfer = awvalid && awready;
    assign w_xfer  = wvalid && wready;

    // Either order of acceptance finishes the address phase
    assign wr_addr_done = (aw_done || aw_xfer) && (w_done || w_xfer);

    assign aw = '{addr: cmd_q.addr, wdata: cmd_q.wdata, wstrb: cmd_q.wstrb};
    assign araddr = cmd_q.addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (fifo_valid) begin
                        state <= (fifo_cmd.op == axil_pkg::OP_WRITE) ? WR_ADDR : RD_ADDR;
                    end
                end
                WR_ADDR: begin
                    if (wr_addr_done) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        state   <= WR_RESP;
                    end else begin
                        aw_done <= aw_done || aw_xfer;
                        w_done  <= w_done || w_xfer;
                    end
                end
                WR_RESP:  if (bvalid) state <= RSP_HOLD;
                RD_ADDR:  if (arready) state <= RD_DATA;
                RD_DATA:  if (rvalid) state <= RSP_HOLD;
                RSP_HOLD: if (rsp_ack) state <= RSP_WAIT;   // Host has the result
                RSP_WAIT: if (!rsp_ack) state <= IDLE;      // Handshake closed
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            cmd_q <= fifo_cmd;
        end
    end

    // Latch the bus result, held for the whole response handshake
    always_ff @(posedge clk) begin
        if (bvalid && bready) begin
            rsp <= '{op: axil_pkg::OP_WRITE, resp: bresp, rdata: '0};
        end else if (rvalid && rready) begin
            rsp <= '{op: axil_pkg::OP_READ, resp: rresp, rdata: rdata};
        end
    end

    // AXI rule: a raised valid keeps its payload until the transfer
    assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("awvalid or AW payload changed before acceptance");

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before acceptance");

endmodule

// File: source/axil_reg_slave.sv
`timescale 1ns/10ps

module axil_reg_slave #(
    parameter int num_regs = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    input  axil_pkg::axil_aw_t                aw,
    input  logic                              awvalid,
    input  logic                              wvalid,
    output logic                              awready,
    output logic                              wready,
    output axil_pkg::axil_resp_e              bresp,
    output logic                              bvalid,
    input  logic                              bready,
    input  logic [axil_pkg::addr_w-1:0]       araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [axil_pkg::data_w-1:0]       rdata,
    output axil_pkg::axil_resp_e              rresp,
    output logic                              rvalid,
    input  logic                              rready
);
    localparam int idx_w = (num_regs > 1) ? $clog2(num_regs) : 1;

    logic [axil_pkg::data_w-1:0] regs [num_regs];

    logic                        wr_ready;   // Shared by AW and W
    logic                        wr_xfer;
    logic                        rd_xfer;
    logic [axil_pkg::addr_w-3:0] wr_word;
    logic [axil_pkg::addr_w-3:0] rd_word;
    logic                        wr_hit;
    logic                        rd_hit;

    assign awready = wr_ready;
    assign wready  = wr_ready;

    assign wr_xfer = wr_ready && awvalid && wvalid;
    assign rd_xfer = arready && arvalid;

    // Word index, byte offset bits are ignored
    assign wr_word = aw.addr[axil_pkg::addr_w-1:2];
    assign rd_word = araddr[axil_pkg::addr_w-1:2];
    assign wr_hit  = (wr_word < num_regs);
    assign rd_hit  = (rd_word < num_regs);

    // Write side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= axil_pkg::RESP_OKAY;
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // One-cycle ready pulse, never while a B is outstanding
            wr_ready <= awvalid && wvalid && !wr_ready && !bvalid;
            if (wr_xfer) begin
                bvalid <= 1'b1;
                bresp  <= wr_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
                if (wr_hit) begin
                    for (int b = 0; b < axil_pkg::strb_w; b++) begin
                        if (aw.wstrb[b]) begin
                            regs[wr_word[idx_w-1:0]][b*8 +: 8] <= aw.wdata[b*8 +: 8];
                        end
                    end
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Read side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= axil_pkg::RESP_OKAY;
            rdata   <= '0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_xfer) begin
                rvalid <= 1'b1;
                rresp  <= rd_hit ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
                rdata  <= rd_hit ? regs[rd_word[idx_w-1:0]] : '0;   // Zero outside the bank
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Responses hold until the master takes them
    assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped or bresp changed before bready");

    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("rvalid dropped or R payload changed before rready");

endmodule

// File: source/axil_subsys_top.sv
`timescale 1ns/10ps

module axil_subsys_top #(
    parameter int fifo_depth = 4,
    parameter int num_regs   = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_cmd_t cmd,
    input  logic                cmd_req,
    output logic                cmd_ack,
    output axil_pkg::axil_rsp_t rsp,
    output logic                rsp_req,
    input  logic                rsp_ack
);
    // FIFO to master
    axil_pkg::axil_cmd_t         fifo_cmd;
    logic                        fifo_valid;
    logic                        fifo_pop;

    // AXI4-Lite bus between master and slave
    axil_pkg::axil_aw_t          aw;
    logic                        awvalid;
    logic                        wvalid;
    logic                        awready;
    logic                        wready;
    axil_pkg::axil_resp_e        bresp;
    logic                        bvalid;
    logic                        bready;
    logic [axil_pkg::addr_w-1:0] araddr;
    logic                        arvalid;
    logic                        arready;
    logic [axil_pkg::data_w-1:0] rdata;
    axil_pkg::axil_resp_e        rresp;
    logic                        rvalid;
    logic                        rready;

    axil_cmd_fifo #(.fifo_depth(fifo_depth)) fifo0 (
        .clk, .rst, .cmd, .cmd_req, .cmd_ack,
        .fifo_cmd, .fifo_valid, .fifo_pop
    );

    axil_master master0 (
        .clk, .rst,
        .fifo_cmd, .fifo_valid, .fifo_pop,
        .aw, .awvalid, .wvalid, .awready, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .rsp, .rsp_req, .rsp_ack
    );

    axil_reg_slave #(.num_regs(num_regs)) slave0 (
        .clk, .rst,
        .aw, .awvalid, .wvalid, .awready, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

endmodule

// File: verif/tb_clkgen.sv
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: verif/tb_axil_subsys.sv
`timescale 1ns/10ps

module tb_axil_subsys;
    localparam int fifo_depth     = 4;
    localparam int num_regs       = 16;
    localparam int cycles_per_cmd = 20;   // Worst case per command incl. rsp_ack delay
    localparam int max_cmds       = 300;  // About 266 commands rounded up
    localparam int timeout_cycles = max_cmds * cycles_per_cmd;

    logic                        clk;
    logic                        rst;
    axil_pkg::axil_cmd_t         cmd;
    logic                        cmd_req;
    logic                        cmd_ack;
    axil_pkg::axil_rsp_t         rsp;
    logic                        rsp_req;
    logic                        rsp_ack;

    logic [axil_pkg::data_w-1:0] model_regs [num_regs];   // Reference register bank
    axil_pkg::axil_rsp_t         exp_q [$];                // Expected results in command order
    int                          cycle_count = 0;

    tb_clkgen #(.period_ns(8), .reset_cycles(10)) clkgen0 (.clk, .rst);

    axil_subsys_top #(.fifo_depth(fifo_depth), .num_regs(num_regs)) dut0 (
        .clk, .rst, .cmd, .cmd_req, .cmd_ack, .rsp, .rsp_req, .rsp_ack
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", timeout_cycles));
        end
    end

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_rsp(input axil_pkg::axil_rsp_t got, input axil_pkg::axil_rsp_t exp);
        if (got.op !== exp.op) begin
            fail_run($sformatf("MISMATCH at %0t: rsp.op got %0d expected %0d",
                               $time, got.op, exp.op));
        end else if (got.resp !== exp.resp) begin
            fail_run($sformatf("MISMATCH at %0t: rsp.resp got %0d expected %0d",
                               $time, got.resp, exp.resp));
        end else if (got.rdata !== exp.rdata) begin
            fail_run($sformatf("MISMATCH at %0t: rsp.rdata got %h expected %h",
                               $time, got.rdata, exp.rdata));
        end
    endtask

    function automatic axil_pkg::axil_cmd_t make_cmd(
        input axil_pkg::axil_op_e          op,
        input logic [axil_pkg::addr_w-1:0] addr,
        input logic [axil_pkg::data_w-1:0] wdata,
        input logic [axil_pkg::strb_w-1:0] wstrb
    );
        axil_pkg::axil_cmd_t c;
        c.op    = op;
        c.addr  = addr;
        c.wdata = wdata;
        c.wstrb = wstrb;
        return c;
    endfunction

    // Word decode and byte strobes in command order
    task automatic model_apply(input axil_pkg::axil_cmd_t c, output axil_pkg::axil_rsp_t r);
        logic [axil_pkg::addr_w-3:0] word;
        logic                        hit;
        word    = c.addr[axil_pkg::addr_w-1:2];
        hit     = (word < num_regs);
        r.op    = c.op;
        r.rdata = '0;
        if (hit) begin
            r.resp = axil_pkg::RESP_OKAY;
        end else begin
            r.resp = axil_pkg::RESP_SLVERR;
        end
        if (c.op == axil_pkg::OP_WRITE && hit) begin
            for (int b = 0; b < axil_pkg::strb_w; b++) begin
                if (c.wstrb[b]) begin
                    model_regs[word][b*8 +: 8] = c.wdata[b*8 +: 8];
                end
            end
        end else if (hit) begin
            r.rdata = model_regs[word];
        end
    endtask

    // Four-phase command handshake on the host side
    task automatic send_cmd(input axil_pkg::axil_cmd_t c);
        @(negedge clk);
        cmd     = c;
        cmd_req = 1'b1;
        @(negedge clk);
        while (!cmd_ack) @(negedge clk);
        cmd_req = 1'b0;
        @(negedge clk);
        while (cmd_ack) @(negedge clk);
    endtask

    task automatic issue_cmd(input axil_pkg::axil_cmd_t c);
        axil_pkg::axil_rsp_t r;
        model_apply(c, r);
        exp_q.push_back(r);
        send_cmd(c);
    endtask

    // Holds rsp_ack off for delay cycles once rsp_req is seen
    task automatic recv_rsp(input int delay, output axil_pkg::axil_rsp_t got);
        @(negedge clk);
        while (!rsp_req) @(negedge clk);
        repeat (delay) @(negedge clk);
        got     = rsp;
        rsp_ack = 1'b1;
        @(negedge clk);
        while (rsp_req) @(negedge clk);
        rsp_ack = 1'b0;
    endtask

    task automatic expect_rsp(input int delay);
        axil_pkg::axil_rsp_t got;
        axil_pkg::axil_rsp_t exp;
        recv_rsp(delay, got);
        if (exp_q.size() == 0) begin
            fail_run("Response arrived with no command outstanding");
        end else begin
            exp = exp_q.pop_front();
            check_rsp(got, exp);
        end
    endtask

    task automatic run_cmd(input axil_pkg::axil_cmd_t c, input int delay);
        issue_cmd(c);
        expect_rsp(delay);
    endtask

    task automatic test_reset_values();
        $display("Test: registers read zero after reset");
        for (int i = 0; i < num_regs; i++) begin
            run_cmd(make_cmd(axil_pkg::OP_READ, i * 4, '0, '0), 0);
        end
    endtask

    task automatic test_full_word();
        logic [axil_pkg::data_w-1:0] data;
        $display("Test: full-word write and read back");
        for (int i = 0; i < 4; i++) begin
            data = $urandom();
            run_cmd(make_cmd(axil_pkg::OP_WRITE, (3 * i + 1) * 4, data, 4'hf), 0);
            run_cmd(make_cmd(axil_pkg::OP_READ, (3 * i + 1) * 4, '0, '0), 1);
        end
    endtask

    task automatic test_byte_strobes();
        logic [15:0] mixed = 16'b0000_0110_1010_0101;   // Four mixed strobe patterns
        logic [3:0]  strb;
        $display("Test: byte strobes");
        run_cmd(make_cmd(axil_pkg::OP_WRITE, 5 * 4, 32'h1122_3344, 4'hf), 0);
        for (int k = 0; k < 8; k++) begin
            if (k < 4) begin
                strb = 4'b0001 << k;
            end else begin
                strb = mixed[(k - 4) * 4 +: 4];
            end
            run_cmd(make_cmd(axil_pkg::OP_WRITE, 5 * 4, $urandom(), strb), 0);
            run_cmd(make_cmd(axil_pkg::OP_READ, 5 * 4, '0, '0), 0);
        end
    endtask

    task automatic test_decode_error();
        $display("Test: out-of-range addresses");
        run_cmd(make_cmd(axil_pkg::OP_READ, num_regs * 4, '0, '0), 0);
        run_cmd(make_cmd(axil_pkg::OP_WRITE, num_regs * 4 + 8, 32'hdead_beef, 4'hf), 0);
        run_cmd(make_cmd(axil_pkg::OP_READ, 32'hffff_fffc, '0, '0), 0);
        for (int i = 0; i < num_regs; i++) begin
            run_cmd(make_cmd(axil_pkg::OP_READ, i * 4, '0, '0), 0);   // Bank unchanged
        end
    endtask

    // Even entries write and odd entries read back the previous one
    function automatic axil_pkg::axil_cmd_t backlog_cmd(input int i);
        if (i % 2 == 0) begin
            return make_cmd(axil_pkg::OP_WRITE, (8 + i) * 4, 32'ha5a5_0000 | i, 4'hf);
        end
        return make_cmd(axil_pkg::OP_READ, (8 + i - 1) * 4, '0, '0);
    endfunction

    task automatic test_back_pressure();
        axil_pkg::axil_cmd_t c;
        axil_pkg::axil_rsp_t r;
        $display("Test: back-pressure with rsp_ack held off");
        // One command in the master and the rest in the FIFO
        for (int i = 0; i < fifo_depth + 1; i++) begin
            issue_cmd(backlog_cmd(i));
        end
        c = backlog_cmd(fifo_depth + 1);
        model_apply(c, r);
        exp_q.push_back(r);
        @(negedge clk);
        cmd     = c;
        cmd_req = 1'b1;
        repeat (2 * cycles_per_cmd) begin
            @(negedge clk);
            check_bit(cmd_ack, 1'b0, "cmd_ack");
        end
        expect_rsp(0);   // Frees the master so the FIFO gets room
        while (!cmd_ack) @(negedge clk);
        cmd_req = 1'b0;
        @(negedge clk);
        while (cmd_ack) @(negedge clk);
        repeat (fifo_depth + 1) begin
            expect_rsp($urandom_range(0, 3));
        end
    endtask

    task automatic test_random(input int n);
        axil_pkg::axil_op_e          op;
        logic [axil_pkg::addr_w-1:0] addr;
        $display("Test: %0d random commands", n);
        for (int i = 0; i < n; i++) begin
            op = axil_pkg::axil_op_e'($urandom_range(0, 1));
            if ($urandom_range(0, 9) == 0) begin
                addr = $urandom();   // Mostly far outside the bank
            end else begin
                addr = $urandom_range(0, num_regs + 3) * 4;
            end
            run_cmd(make_cmd(op, addr, $urandom(), 4'($urandom())), $urandom_range(0, 4));
        end
    endtask

    initial begin
        cmd     = '0;
        cmd_req = 1'b0;
        rsp_ack = 1'b0;
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(72454));
        wait (rst == 1'b0);
        @(negedge clk);

        test_reset_values();
        test_full_word();
        test_byte_strobes();
        test_decode_error();
        test_back_pressure();
        test_random(200);

        if (exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_run("Run ended with unmatched expected responses");
        end
    end

endmodule

// File: compile.f
source/axil_pkg.sv
source/axil_cmd_fifo.sv
source/axil_master.sv
source/axil_reg_slave.sv
source/axil_subsys_top.sv
verif/tb_clkgen.sv
verif/tb_axil_subsys.sv

// File: Bender.yml
package:
  name: axil_subsys

sources:
  - source/axil_pkg.sv
  - source/axil_cmd_fifo.sv
  - source/axil_master.sv
  - source/axil_reg_slave.sv
  - source/axil_subsys_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/tb_axil_subsys.sv
